//--- dpmem_pkg.sv
/*
 * Shared types for the two-port Wishbone memory.
 * Word and address widths are fixed here; the request struct depends on them.
 * 256 words of 32 bits, four byte lanes.
 */
package dpmem_pkg;

    localparam int BYTE_WIDTH = 8;
    localparam int BYTE_NUM   = 4;
    localparam int ADDR_WIDTH = 8;
    localparam int MEM_WIDTH  = BYTE_WIDTH * BYTE_NUM;

    typedef logic [MEM_WIDTH-1:0]  mem_word_t;
    typedef logic [ADDR_WIDTH-1:0] mem_addr_t;
    // Also used as the Wishbone sel
    typedef logic [BYTE_NUM-1:0]   byte_en_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // One request from a port controller to the RAM
    typedef struct packed {
        logic      valid;
        mem_op_e   op;
        mem_addr_t addr;
        byte_en_t  byte_en;
        mem_word_t wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_WAIT = 2'd1,
        ST_ACK  = 2'd2
    } port_state_e;

endpackage

//--- wb_mem_port.sv
/*
 * Wishbone classic slave front end for one memory port.
 * The master must hold cyc, stb and all request fields until ack.
 * No err, rty or burst cycles. One cycle outstanding at a time.
 * ack comes a fixed number of clocks after the cycle is accepted.
 */
module wb_mem_port
    import dpmem_pkg::*;
(
    input  logic      a_clk_i,
    input  logic      rst_n_i,

    input  logic      cyc_i,
    input  logic      stb_i,
    input  logic      we_i,
    input  mem_addr_t adr_i,
    input  byte_en_t  sel_i,
    input  mem_word_t dat_i,
    output mem_word_t dat_o,
    output logic      ack_o,

    output mem_req_t  req_o,
    input  logic      rsp_valid_i,
    input  mem_word_t rsp_data_i
);

    port_state_e state_q;
    port_state_e state_d;
    mem_req_t    req_q;
    mem_word_t   rsp_q;
    logic        start;

    assign start = (state_q == ST_IDLE) && cyc_i && stb_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (cyc_i && stb_i) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (rsp_valid_i) begin
                    state_d = ST_ACK;
                end
            end
            ST_ACK:  state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge a_clk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request is valid for exactly one clock per bus cycle
    always_ff @(posedge a_clk_i) begin
        if (!rst_n_i) begin
            req_q.valid <= 1'b0;
        end else begin
            req_q.valid <= start;
            if (start) begin
                req_q.op      <= we_i ? OP_WRITE : OP_READ;
                req_q.addr    <= adr_i;
                req_q.byte_en <= sel_i;
                req_q.wdata   <= dat_i;
            end
        end
    end

    // Read word held for the ack cycle
    always_ff @(posedge a_clk_i) begin
        if (rsp_valid_i) begin
            rsp_q <= rsp_data_i;
        end
    end

    assign req_o = req_q;
    assign ack_o = (state_q == ST_ACK);
    assign dat_o = rsp_q;

    ack_within_cycle: assert property (
        @(posedge a_clk_i) disable iff (!rst_n_i)
        ack_o |-> (cyc_i && stb_i)
    ) else $error("ack raised outside an active bus cycle");

    no_orphan_rsp: assert property (
        @(posedge a_clk_i) disable iff (!rst_n_i)
        rsp_valid_i |-> (state_q != ST_IDLE)
    ) else $error("memory response with no cycle outstanding");

endmodule

//--- ram_true_dp.sv
/*
 * True dual-port RAM with per-lane byte writes, both ports on one clock.
 * MEM_MODE picks the read port behavior on writes:
 * no_change, read_first or write_first. Other values stop elaboration.
 * Contents are not initialised. If both ports write one address in a clock, B wins.
 */
module ram_true_dp
    import dpmem_pkg::*;
#(
    parameter MEM_MODE = "no_change"
) (
    input  logic      a_clk_i,
    input  logic      rst_n_i,

    input  mem_req_t  a_req_i,
    output mem_word_t a_data_o,
    output logic      a_valid_o,

    input  mem_req_t  b_req_i,
    output mem_word_t b_data_o,
    output logic      b_valid_o
);

    localparam int MEM_DEPTH = 2 ** ADDR_WIDTH;

    mem_word_t ram [MEM_DEPTH];
    logic      a_wr;
    logic      b_wr;

    assign a_wr = a_req_i.valid && (a_req_i.op == OP_WRITE);
    assign b_wr = b_req_i.valid && (b_req_i.op == OP_WRITE);

    // New lanes where enabled, old lanes elsewhere
    function automatic mem_word_t lane_merge(mem_word_t old_w, mem_word_t new_w, byte_en_t be);
        mem_word_t res;
        res = old_w;
        for (int i = 0; i < BYTE_NUM; i++) begin
            if (be[i]) begin
                res[i*BYTE_WIDTH +: BYTE_WIDTH] = new_w[i*BYTE_WIDTH +: BYTE_WIDTH];
            end
        end
        return res;
    endfunction

    always_ff @(posedge a_clk_i) begin
        for (int i = 0; i < BYTE_NUM; i++) begin
            if (a_wr && a_req_i.byte_en[i]) begin
                ram[a_req_i.addr][i*BYTE_WIDTH +: BYTE_WIDTH] <=
                    a_req_i.wdata[i*BYTE_WIDTH +: BYTE_WIDTH];
            end
            if (b_wr && b_req_i.byte_en[i]) begin
                ram[b_req_i.addr][i*BYTE_WIDTH +: BYTE_WIDTH] <=
                    b_req_i.wdata[i*BYTE_WIDTH +: BYTE_WIDTH];
            end
        end
    end

    if (MEM_MODE == "no_change") begin : g_no_change
        always_ff @(posedge a_clk_i) begin
            if (a_req_i.valid && !a_wr) begin
                a_data_o <= ram[a_req_i.addr];
            end
            if (b_req_i.valid && !b_wr) begin
                b_data_o <= ram[b_req_i.addr];
            end
        end
    end else if (MEM_MODE == "read_first") begin : g_rd_first
        always_ff @(posedge a_clk_i) begin
            if (a_req_i.valid) begin
                a_data_o <= ram[a_req_i.addr];
            end
            if (b_req_i.valid) begin
                b_data_o <= ram[b_req_i.addr];
            end
        end
    end else if (MEM_MODE == "write_first") begin : g_wr_first
        always_ff @(posedge a_clk_i) begin
            if (a_req_i.valid) begin
                a_data_o <= a_wr ? lane_merge(ram[a_req_i.addr], a_req_i.wdata, a_req_i.byte_en)
                                 : ram[a_req_i.addr];
            end
            if (b_req_i.valid) begin
                b_data_o <= b_wr ? lane_merge(ram[b_req_i.addr], b_req_i.wdata, b_req_i.byte_en)
                                 : ram[b_req_i.addr];
            end
        end
    end else begin : g_mode_err
        $error("MEM_MODE must be no_change, read_first or write_first");
    end

    // Response valid lines up with the registered read word
    always_ff @(posedge a_clk_i) begin
        if (!rst_n_i) begin
            a_valid_o <= 1'b0;
            b_valid_o <= 1'b0;
        end else begin
            a_valid_o <= a_req_i.valid;
            b_valid_o <= b_req_i.valid;
        end
    end

    no_write_collision: assert property (
        @(posedge a_clk_i) disable iff (!rst_n_i)
        !(a_wr && b_wr && (a_req_i.addr == b_req_i.addr))
    ) else $error("both ports write address %0h in one cycle", a_req_i.addr);

endmodule

//--- rd_return_pipe.sv
/*
 * Delay line for the RAM read word and its valid bit.
 * PIPE_NUM stages; 0 passes both straight through.
 * Only the valid bits are reset.
 */
module rd_return_pipe
    import dpmem_pkg::*;
#(
    parameter int PIPE_NUM = 2
) (
    input  logic      a_clk_i,
    input  logic      rst_n_i,
    input  logic      valid_i,
    input  mem_word_t data_i,
    output logic      valid_o,
    output mem_word_t data_o
);

    if (PIPE_NUM == 0) begin : g_bypass
        assign valid_o = valid_i;
        assign data_o  = data_i;
    end else begin : g_pipe
        logic [PIPE_NUM-1:0] valid_q;
        mem_word_t           data_q [PIPE_NUM];

        always_ff @(posedge a_clk_i) begin
            if (!rst_n_i) begin
                valid_q <= '0;
            end else begin
                valid_q[0] <= valid_i;
                for (int i = 1; i < PIPE_NUM; i++) begin
                    valid_q[i] <= valid_q[i-1];
                end
            end
        end

        // Stages only load behind a valid word
        always_ff @(posedge a_clk_i) begin
            if (valid_i) begin
                data_q[0] <= data_i;
            end
            for (int i = 1; i < PIPE_NUM; i++) begin
                if (valid_q[i-1]) begin
                    data_q[i] <= data_q[i-1];
                end
            end
        end

        assign valid_o = valid_q[PIPE_NUM-1];
        assign data_o  = data_q[PIPE_NUM-1];
    end

endmodule

//--- dpmem_top.sv
/*
 * Shared memory with two Wishbone classic slave ports, A and B.
 * ack comes 2 + PIPE_NUM clocks after a cycle is first seen; no stalls.
 * Both ports share a_clk_i. Simultaneous writes to one address are illegal.
 */
module dpmem_top
    import dpmem_pkg::*;
#(
    parameter int PIPE_NUM = 2,
    parameter     MEM_MODE = "no_change"
) (
    input  logic      a_clk_i,
    input  logic      rst_n_i,

    input  logic      wba_cyc_i,
    input  logic      wba_stb_i,
    input  logic      wba_we_i,
    input  mem_addr_t wba_adr_i,
    input  byte_en_t  wba_sel_i,
    input  mem_word_t wba_dat_i,
    output mem_word_t wba_dat_o,
    output logic      wba_ack_o,

    input  logic      wbb_cyc_i,
    input  logic      wbb_stb_i,
    input  logic      wbb_we_i,
    input  mem_addr_t wbb_adr_i,
    input  byte_en_t  wbb_sel_i,
    input  mem_word_t wbb_dat_i,
    output mem_word_t wbb_dat_o,
    output logic      wbb_ack_o
);

    mem_req_t  a_req;
    mem_req_t  b_req;
    mem_word_t a_ram_data;
    mem_word_t b_ram_data;
    logic      a_ram_valid;
    logic      b_ram_valid;
    mem_word_t a_rsp_data;
    mem_word_t b_rsp_data;
    logic      a_rsp_valid;
    logic      b_rsp_valid;

    wb_mem_port u_port_a (
        .a_clk_i(a_clk_i), .rst_n_i(rst_n_i),
        .cyc_i(wba_cyc_i), .stb_i(wba_stb_i), .we_i(wba_we_i),
        .adr_i(wba_adr_i), .sel_i(wba_sel_i), .dat_i(wba_dat_i),
        .dat_o(wba_dat_o), .ack_o(wba_ack_o),
        .req_o(a_req), .rsp_valid_i(a_rsp_valid), .rsp_data_i(a_rsp_data)
    );

    wb_mem_port u_port_b (
        .a_clk_i(a_clk_i), .rst_n_i(rst_n_i),
        .cyc_i(wbb_cyc_i), .stb_i(wbb_stb_i), .we_i(wbb_we_i),
        .adr_i(wbb_adr_i), .sel_i(wbb_sel_i), .dat_i(wbb_dat_i),
        .dat_o(wbb_dat_o), .ack_o(wbb_ack_o),
        .req_o(b_req), .rsp_valid_i(b_rsp_valid), .rsp_data_i(b_rsp_data)
    );

    ram_true_dp #(.MEM_MODE(MEM_MODE)) u_ram (
        .a_clk_i(a_clk_i), .rst_n_i(rst_n_i),
        .a_req_i(a_req), .a_data_o(a_ram_data), .a_valid_o(a_ram_valid),
        .b_req_i(b_req), .b_data_o(b_ram_data), .b_valid_o(b_ram_valid)
    );

    rd_return_pipe #(.PIPE_NUM(PIPE_NUM)) u_pipe_a (
        .a_clk_i(a_clk_i), .rst_n_i(rst_n_i),
        .valid_i(a_ram_valid), .data_i(a_ram_data),
        .valid_o(a_rsp_valid), .data_o(a_rsp_data)
    );

    rd_return_pipe #(.PIPE_NUM(PIPE_NUM)) u_pipe_b (
        .a_clk_i(a_clk_i), .rst_n_i(rst_n_i),
        .valid_i(b_ram_valid), .data_i(b_ram_data),
        .valid_o(b_rsp_valid), .data_o(b_rsp_data)
    );

endmodule

//--- tb_clk_gen.sv
/*
 * Testbench clock and synchronous active-low reset.
 * Reset is released on a falling edge after RESET_CYCLES rising edges.
 */
module tb_clk_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

//--- tb_dpmem.sv
/*
 * Directed tests for dpmem_top with PIPE_NUM 2 in no_change mode.
 * Bus inputs change on the falling edge; outputs are sampled there too.
 * Reads only target words written earlier in the run because the RAM is not reset.
 */
module tb_dpmem
    import dpmem_pkg::*;
();

    localparam int PIPE_NUM = 2;
    localparam int LATENCY  = 2 + PIPE_NUM;
    localparam int N_RW     = 8;
    localparam int N_LANE   = 4;
    localparam int N_CROSS  = 3;
    localparam int N_CONC   = 6;
    localparam int NUM_TXN  = 2 * N_RW + 3 * N_LANE + 4 * N_CROSS + N_CONC;
    localparam int TIMEOUT  = NUM_TXN * (LATENCY + 4) + 50;

    // Master side of one Wishbone port
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        mem_addr_t adr;
        byte_en_t  sel;
        mem_word_t dat;
    } wb_drive_t;

    logic      a_clk;
    logic      rst_n;
    wb_drive_t drv_a;
    wb_drive_t drv_b;
    mem_word_t wba_dat;
    mem_word_t wbb_dat;
    logic      wba_ack;
    logic      wbb_ack;

    mem_word_t model [2 ** ADDR_WIDTH];
    mem_addr_t written [$];
    int        seed = 45;
    int        cycle_cnt = 0;
    int        err_word = 0;
    int        err_lat = 0;
    int        err_ack = 0;

    tb_clk_gen #(.PERIOD(40), .RESET_CYCLES(2)) u_clk_gen (.clk_o(a_clk), .rst_n_o(rst_n));

    dpmem_top #(.PIPE_NUM(PIPE_NUM), .MEM_MODE("no_change")) DUT (
        .a_clk_i(a_clk), .rst_n_i(rst_n),
        .wba_cyc_i(drv_a.cyc), .wba_stb_i(drv_a.stb), .wba_we_i(drv_a.we),
        .wba_adr_i(drv_a.adr), .wba_sel_i(drv_a.sel), .wba_dat_i(drv_a.dat),
        .wba_dat_o(wba_dat), .wba_ack_o(wba_ack),
        .wbb_cyc_i(drv_b.cyc), .wbb_stb_i(drv_b.stb), .wbb_we_i(drv_b.we),
        .wbb_adr_i(drv_b.adr), .wbb_sel_i(drv_b.sel), .wbb_dat_i(drv_b.dat),
        .wbb_dat_o(wbb_dat), .wbb_ack_o(wbb_ack)
    );

    task automatic check_word(input string name, input mem_word_t exp, input mem_word_t act);
        if (act !== exp) begin
            err_word++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            err_lat++;
            $display("[ERROR] %s: expected ack after %0d edges, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_ack_idle(input string name, input logic ack);
        if (ack !== 1'b0) begin
            err_ack++;
            $display("[ERROR] %s: expected ack 0, actual %b", name, ack);
        end
    endtask

    task automatic set_port(input logic port_b, input wb_drive_t d);
        if (port_b) begin
            drv_b = d;
        end else begin
            drv_a = d;
        end
    endtask

    function automatic logic ack_of(input logic port_b);
        return port_b ? wbb_ack : wba_ack;
    endfunction

    // One classic cycle; counts rising edges from the one that first sees stb
    task automatic bus_cycle(input logic port_b, input string name, input logic we,
                             input mem_addr_t adr, input byte_en_t sel,
                             input mem_word_t wdata, output mem_word_t rdata);
        int edges;
        @(negedge a_clk);
        set_port(port_b, {1'b1, 1'b1, we, adr, sel, wdata});
        edges = 0;
        @(posedge a_clk);
        @(negedge a_clk);
        while (!ack_of(port_b)) begin
            @(posedge a_clk);
            edges++;
            @(negedge a_clk);
        end
        rdata = port_b ? wbb_dat : wba_dat;
        check_latency(name, LATENCY, edges);
        // Master takes ack on this edge and then lets go
        @(posedge a_clk);
        @(negedge a_clk);
        check_ack_idle(name, ack_of(port_b));
        set_port(port_b, '0);
    endtask

    task automatic model_write(input mem_addr_t adr, input mem_word_t data, input byte_en_t sel);
        for (int i = 0; i < BYTE_NUM; i++) begin
            if (sel[i]) begin
                model[adr][i*BYTE_WIDTH +: BYTE_WIDTH] = data[i*BYTE_WIDTH +: BYTE_WIDTH];
            end
        end
    endtask

    task automatic write_word(input logic port_b, input string name, input mem_addr_t adr,
                              input byte_en_t sel, input mem_word_t data);
        mem_word_t ignored;
        bus_cycle(port_b, name, 1'b1, adr, sel, data, ignored);
        model_write(adr, data, sel);
        written.push_back(adr);
    endtask

    task automatic read_check(input logic port_b, input string name, input mem_addr_t adr);
        mem_word_t rd;
        bus_cycle(port_b, name, 1'b0, adr, '1, '0, rd);
        check_word(name, model[adr], rd);
    endtask

    task automatic test_reset();
        repeat (4) begin
            @(negedge a_clk);
            check_ack_idle("reset", wba_ack);
            check_ack_idle("reset", wbb_ack);
        end
    endtask

    task automatic test_write_read();
        mem_addr_t adrs [N_RW];
        for (int i = 0; i < N_RW; i++) begin
            adrs[i] = mem_addr_t'($random(seed));
            write_word(1'b0, "write_read", adrs[i], '1, mem_word_t'($random(seed)));
        end
        for (int i = 0; i < N_RW; i++) begin
            read_check(1'b0, "write_read", adrs[i]);
        end
    endtask

    task automatic test_byte_lanes();
        byte_en_t  pats [N_LANE] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
        mem_addr_t adr;
        for (int i = 0; i < N_LANE; i++) begin
            adr = mem_addr_t'($random(seed));
            write_word(1'b0, "byte_lanes", adr, '1, mem_word_t'($random(seed)));
            write_word(1'b0, "byte_lanes", adr, pats[i], mem_word_t'($random(seed)));
            read_check(1'b0, "byte_lanes", adr);
        end
    endtask

    task automatic test_cross_port();
        mem_addr_t adr;
        for (int i = 0; i < N_CROSS; i++) begin
            adr = mem_addr_t'($random(seed));
            write_word(1'b1, "cross_b_to_a", adr, '1, mem_word_t'($random(seed)));
            read_check(1'b0, "cross_b_to_a", adr);
            adr = mem_addr_t'($random(seed));
            write_word(1'b0, "cross_a_to_b", adr, '1, mem_word_t'($random(seed)));
            read_check(1'b1, "cross_a_to_b", adr);
        end
    endtask

    // Reader and writer swap ports each round and never share an address
    task automatic test_concurrent();
        mem_addr_t rd_adr;
        mem_addr_t wr_adr;
        mem_word_t data;
        for (int i = 0; i < N_CONC; i++) begin
            rd_adr = written[$unsigned($random(seed)) % written.size()];
            wr_adr = rd_adr + mem_addr_t'(1 + $unsigned($random(seed)) % 255);
            data   = mem_word_t'($random(seed));
            fork
                write_word(!i[0], "concurrent", wr_adr, '1, data);
                read_check(i[0], "concurrent", rd_adr);
            join
        end
    endtask

    always @(posedge a_clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        drv_a = '0;
        drv_b = '0;
        test_reset();
        test_write_read();
        test_byte_lanes();
        test_cross_port();
        test_concurrent();
        $display("Error counts: data %0d, latency %0d, ack %0d", err_word, err_lat, err_ack);
        if (err_word + err_lat + err_ack == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- filelist.f
dpmem_pkg.sv
wb_mem_port.sv
ram_true_dp.sv
rd_return_pipe.sv
dpmem_top.sv
tb_clk_gen.sv
tb_dpmem.sv
